// ==== rtl/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Cache model behaviour.
`define FETCH_MISS_FREQ 2         // Hits between two misses in a bank.
`define FETCH_REFILL_CYCLES 4     // Idle cycles after a miss before the retry.

// Stub branch predictor.
`define FETCH_RESTEER_PERIOD 12   // Delivered windows between predicted redirects.
`define FETCH_RESTEER_STRIDE 8    // Lines past the last delivered window.

// Fetch start point.
`define FETCH_RESET_FIP 28'h0000100

// Bank signatures in the low bits of every line.
`define FETCH_SIG_EVEN 96'hBEEF0000FEED
`define FETCH_SIG_ODD 96'hDEAD0000DEAD

`endif

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int FIP_W    = 28;
    localparam int WINDOW_W = 256;

    typedef logic [FIP_W-1:0]    fip_t;     // 16-byte line address.
    typedef logic [WINDOW_W-1:0] window_t;  // Two lines, lower address in the low half.

    ////////////////////////////////////////////////////////////////////////////
    // Pairing rule: both lines of a pair are the start rounded up to their bank.
    ////////////////////////////////////////////////////////////////////////////

    function automatic fip_t pair_even(input fip_t f);
        pair_even = f + fip_t'(f[0]);  // Odd start moves to the next even line.
    endfunction

    function automatic fip_t pair_odd(input fip_t f);
        pair_odd = {f[FIP_W-1:1], 1'b1};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    localparam int LINE_W      = 128;
    localparam int BANK_ADDR_W = 27;
    localparam int SIG_W       = 96;
    localparam int PAD_W       = LINE_W - BANK_ADDR_W - SIG_W;

    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [BANK_ADDR_W-1:0] bank_addr_t;  // FIP without the bank-select bit.

    // Model line: address, zero pad, then the bank signature.
    function automatic line_t make_line(input bank_addr_t addr, input logic [SIG_W-1:0] sig);
        make_line = {addr, {PAD_W{1'b0}}, sig};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/icache_if.sv ====
`default_nettype none

interface icache_if
    import fetch_pkg::*, icache_pkg::*;
();

    fip_t  fip_even;
    fip_t  fip_odd;
    logic  oe;         // One strobe, both banks always go together.
    line_t line_even;
    line_t line_odd;
    logic  miss;       // Either bank missed.

    modport fetch (
        output fip_even,
        output fip_odd,
        output oe,
        input  line_even,
        input  line_odd,
        input  miss
    );

    modport cache (
        input  fip_even,
        input  fip_odd,
        input  oe,
        output line_even,
        output line_odd,
        output miss
    );

endinterface

`default_nettype wire

// ==== rtl/icache_bank.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module icache_bank
    import icache_pkg::*;
#(
    parameter bit ODD_BANK = 1'b0
) (
    input  logic       clk,
    input  logic       rst,
    input  bank_addr_t addr,
    input  logic       oe,
    output logic       miss,
    output line_t      line
);

    localparam int CNT_W = (`FETCH_MISS_FREQ > 0) ? $clog2(`FETCH_MISS_FREQ + 1) : 1;
    localparam logic [CNT_W-1:0] MISS_AT = CNT_W'(`FETCH_MISS_FREQ);
    localparam logic [SIG_W-1:0] SIG = ODD_BANK ? SIG_W'(`FETCH_SIG_ODD)
                                                : SIG_W'(`FETCH_SIG_EVEN);

    logic [CNT_W-1:0] access_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Periodic miss, every (MISS_AT+1)-th access
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            access_cnt <= '0;
            miss       <= 1'b0;
        end else if (oe) begin
            if (access_cnt == MISS_AT) begin
                access_cnt <= '0;
                miss       <= 1'b1;
            end else begin
                access_cnt <= access_cnt + 1'b1;
                miss       <= 1'b0;
            end
        end
    end

    // Line data holds between accesses.
    always_ff @(posedge clk) begin
        if (oe) begin
            line <= make_line(addr, SIG);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/icache.sv ====
`default_nettype none

module icache
    import icache_pkg::*;
(
    input logic     clk,
    input logic     rst,
    icache_if.cache bus
);

    bank_addr_t addr_even;
    bank_addr_t addr_odd;
    logic       miss_even;
    logic       miss_odd;

    // Bit 0 selects the bank and is not part of the bank address.
    assign addr_even = bus.fip_even[BANK_ADDR_W:1];
    assign addr_odd  = bus.fip_odd[BANK_ADDR_W:1];

    icache_bank #(
        .ODD_BANK (1'b0)
    ) even_bank_i (
        .clk  (clk),
        .rst  (rst),
        .addr (addr_even),
        .oe   (bus.oe),
        .miss (miss_even),
        .line (bus.line_even)
    );

    icache_bank #(
        .ODD_BANK (1'b1)
    ) odd_bank_i (
        .clk  (clk),
        .rst  (rst),
        .addr (addr_odd),
        .oe   (bus.oe),
        .miss (miss_odd),
        .line (bus.line_odd)
    );

    assign bus.miss = miss_even | miss_odd;  // Counters track, so both miss together.

endmodule

`default_nettype wire

// ==== rtl/fetch_pointer.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module fetch_pointer
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    init_valid,
    input  fip_t    init_fip,
    input  logic    stall,
    input  logic    resteer,
    input  fip_t    resteer_fip,
    icache_if.fetch bus,
    output logic    fetch_valid,
    output fip_t    fetch_fip,
    output window_t fetch_window
);

    localparam int REFILL_W = (`FETCH_REFILL_CYCLES > 0) ? $clog2(`FETCH_REFILL_CYCLES + 1) : 1;
    localparam logic [REFILL_W-1:0] REFILL_LOAD = REFILL_W'(`FETCH_REFILL_CYCLES);
    localparam fip_t RESET_FIP = `FETCH_RESET_FIP;

    fip_t                fip_even_q;
    fip_t                fip_odd_q;
    fip_t                flt_even_q;   // Pair of the access in flight.
    fip_t                flt_odd_q;
    logic                inflight_q;
    logic                squash_q;
    logic [REFILL_W-1:0] refill_cnt;

    logic redirect;
    fip_t redirect_fip;
    logic miss_seen;
    logic rewind;
    logic issue;
    logic odd_first;

    ////////////////////////////////////////////////////////////////////////////
    // Issue control
    ////////////////////////////////////////////////////////////////////////////

    assign redirect     = init_valid | resteer;
    assign redirect_fip = init_valid ? init_fip : resteer_fip;  // External strobe wins.

    assign miss_seen = inflight_q & ~squash_q & bus.miss;  // Held miss counts only when live.
    assign rewind    = miss_seen & ~redirect;
    assign issue     = ~rst & ~stall & (refill_cnt == '0) & ~miss_seen;

    assign bus.oe       = issue;
    assign bus.fip_even = fip_even_q;
    assign bus.fip_odd  = fip_odd_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            fip_even_q <= pair_even(RESET_FIP);
            fip_odd_q  <= pair_odd(RESET_FIP);
            refill_cnt <= '0;
        end else if (redirect) begin
            fip_even_q <= pair_even(redirect_fip);
            fip_odd_q  <= pair_odd(redirect_fip);
            refill_cnt <= '0;                       // Redirect ends a refill wait.
        end else if (rewind) begin
            fip_even_q <= flt_even_q;
            fip_odd_q  <= flt_odd_q;
            refill_cnt <= REFILL_LOAD;
        end else begin
            if (issue) begin
                fip_even_q <= fip_even_q + fip_t'(2);
                fip_odd_q  <= fip_odd_q + fip_t'(2);
            end
            if (refill_cnt != '0) begin
                refill_cnt <= refill_cnt - 1'b1;
            end
        end
    end

    // One access in flight at most.
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_q <= 1'b0;
            squash_q   <= 1'b0;
        end else begin
            inflight_q <= issue;
            squash_q   <= issue & redirect;         // Issued from the old stream.
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            flt_even_q <= fip_even_q;
            flt_odd_q  <= fip_odd_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window delivery
    ////////////////////////////////////////////////////////////////////////////

    assign odd_first   = (flt_even_q == flt_odd_q + 1'b1);  // Odd start address.
    assign fetch_valid = inflight_q & ~squash_q & ~bus.miss & ~redirect;
    assign fetch_fip   = odd_first ? flt_odd_q : flt_even_q;

    assign fetch_window = odd_first ? {bus.line_even, bus.line_odd}
                                    : {bus.line_odd, bus.line_even};

endmodule

`default_nettype wire

// ==== rtl/resteer_predictor.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module resteer_predictor
    import fetch_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic fetch_valid,
    input  fip_t fetch_fip,
    input  logic init_valid,
    output logic resteer,
    output fip_t resteer_fip
);

    localparam logic [5:0] LAST_COUNT = 6'(`FETCH_RESTEER_PERIOD - 1);
    localparam fip_t       STRIDE     = fip_t'(`FETCH_RESTEER_STRIDE);

    logic [5:0] deliv_cnt;
    logic       fire;

    assign fire = fetch_valid & (deliv_cnt == LAST_COUNT);  // Delivery that completes the count.

    ////////////////////////////////////////////////////////////////////////////
    // Delivery counter and predicted redirect
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            deliv_cnt <= '0;
            resteer   <= 1'b0;
        end else begin
            resteer <= fire;
            if (init_valid | resteer) begin
                deliv_cnt <= '0;                    // Any redirect restarts the count.
            end else if (fetch_valid) begin
                deliv_cnt <= deliv_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            resteer_fip <= fetch_fip + STRIDE;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_top.sv ====
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    init_valid,
    input  fip_t    init_fip,
    input  logic    stall,
    output logic    fetch_valid,
    output fip_t    fetch_fip,
    output window_t fetch_window,
    output logic    resteer
);

    fip_t resteer_fip;

    icache_if icache_bus ();

    fetch_pointer fetch_pointer_i (
        .clk          (clk),
        .rst          (rst),
        .init_valid   (init_valid),
        .init_fip     (init_fip),
        .stall        (stall),
        .resteer      (resteer),
        .resteer_fip  (resteer_fip),
        .bus          (icache_bus.fetch),
        .fetch_valid  (fetch_valid),
        .fetch_fip    (fetch_fip),
        .fetch_window (fetch_window)
    );

    icache icache_i (
        .clk (clk),
        .rst (rst),
        .bus (icache_bus.cache)
    );

    // Stub predictor watches the delivered stream.
    resteer_predictor resteer_predictor_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_fip   (fetch_fip),
        .init_valid  (init_valid),
        .resteer     (resteer),
        .resteer_fip (resteer_fip)
    );

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released on a falling edge.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/fetch_tb.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb
    import fetch_pkg::*, icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [255:0] value_t;

    localparam int PERIOD       = `FETCH_RESTEER_PERIOD;
    localparam int WIN_CYCLES   = `FETCH_REFILL_CYCLES + 4;  // Worst cycles per window.
    localparam int STALL_CYCLES = 200;
    localparam int RUN_WINDOWS  = (PERIOD + 4) + 18 + 8 + (2 * PERIOD + 1) + 4;
    localparam int WATCHDOG_NS  = 2 * 8 * (3 + RUN_WINDOWS * WIN_CYCLES + STALL_CYCLES);

    logic    clk;
    logic    rst;
    logic    init_valid;
    fip_t    init_fip;
    logic    stall;
    logic    fetch_valid;
    fip_t    fetch_fip;
    window_t fetch_window;
    logic    resteer;

    int          error_count   = 0;
    int          check_count   = 0;
    int          deliv_count   = 0;
    int          resteer_count = 0;
    int          model_count;
    int          idle_run;
    int          max_idle;
    int          stall_run;
    fip_t        exp_fip;         // Next window address the model expects.
    logic        exp_resteer;
    fip_t        resteer_base;    // Model FIP of the window that completed the count.
    fip_t        last_fip;
    window_t     last_window;
    logic [31:0] lfsr_state    = 32'h768f;

    clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(3)) clk_gen_i (.clk(clk), .rst(rst));

    fetch_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .init_valid   (init_valid),
        .init_fip     (init_fip),
        .stall        (stall),
        .fetch_valid  (fetch_valid),
        .fetch_fip    (fetch_fip),
        .fetch_window (fetch_window),
        .resteer      (resteer)
    );

    // Bank address, five zero bits, then the signature of the line's bank.
    function automatic line_t line_content(input fip_t f);
        logic [95:0] sig;
        sig          = f[0] ? `FETCH_SIG_ODD : `FETCH_SIG_EVEN;
        line_content = {f[27:1], 5'b00000, sig};
    endfunction

    function automatic window_t window_content(input fip_t f);
        window_content = {line_content(f + fip_t'(1)), line_content(f)};  // Lower line low.
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int progress(input bit on_resteer);
        progress = on_resteer ? resteer_count : deliv_count;
    endfunction

    task automatic check_value(input string name, input value_t got, input value_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Failure at %0d ns: %s", $time, what);
    endtask

    task automatic report_and_finish();
        $display("Checks %0d, errors %0d, windows %0d, resteers %0d",
                 check_count, error_count, deliv_count, resteer_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic await_progress(input bit on_resteer, input int count, input string what);
        int start;
        int waited;
        start  = progress(on_resteer);
        waited = 0;
        while (progress(on_resteer) < start + count && waited < (count + PERIOD) * WIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (progress(on_resteer) < start + count) begin
            report_failure({"timed out waiting for ", what});
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitor and reference model
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            exp_fip     = `FETCH_RESET_FIP;
            exp_resteer = 1'b0;
            model_count = 0;
            idle_run    = 0;
            max_idle    = 0;
            stall_run   = 0;
        end else begin
            check_value("resteer", value_t'(resteer), value_t'(exp_resteer));
            exp_resteer = 1'b0;
            stall_run   = stall ? stall_run + 1 : 0;
            if (resteer) begin
                resteer_count++;
            end
            if (fetch_valid) begin
                if (stall_run > 1) begin
                    report_failure("window delivered after the first stalled cycle");
                end
                check_value("fetch_fip", value_t'(fetch_fip), value_t'(exp_fip));
                check_value("fetch_window", value_t'(fetch_window),
                            value_t'(window_content(exp_fip)));
                last_fip    = fetch_fip;
                last_window = fetch_window;
                deliv_count++;
                max_idle    = (idle_run > max_idle) ? idle_run : max_idle;
                idle_run    = 0;
                model_count++;
                if (model_count == PERIOD) begin
                    resteer_base = exp_fip;
                    exp_fip      = exp_fip + fip_t'(`FETCH_RESTEER_STRIDE);  // Predicted target.
                    exp_resteer  = 1'b1;
                    model_count  = 0;
                end else begin
                    exp_fip = exp_fip + fip_t'(2);
                end
            end else begin
                idle_run++;
            end
            if (init_valid) begin
                exp_fip     = init_fip;  // External redirect wins over the predictor.
                model_count = 0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic after_reset_stream();
        await_progress(1'b0, 1, "the first window after reset");
        check_value("fetch_fip", value_t'(last_fip), value_t'(`FETCH_RESET_FIP));
        check_value("fetch_window", value_t'(last_window),
                    value_t'(window_content(`FETCH_RESET_FIP)));
        await_progress(1'b0, PERIOD - 1, "a full predictor period of windows");
        check_value("fetch_fip", value_t'(last_fip),
                    value_t'(fip_t'(`FETCH_RESET_FIP) + fip_t'(2 * (PERIOD - 1))));
        await_progress(1'b0, 4, "windows after the first resteer");
    endtask

    task automatic miss_refill_gap();
        max_idle = 0;
        await_progress(1'b0, 18, "windows under periodic misses");
        if (max_idle < `FETCH_REFILL_CYCLES) begin
            report_failure("no refill gap seen between windows");
        end
    endtask

    task automatic external_redirect(input fip_t target);
        @(negedge clk);
        init_valid = 1'b1;
        init_fip   = target;
        @(negedge clk);
        init_valid = 1'b0;
        await_progress(1'b0, 1, "the window at the redirect target");
        check_value("fetch_fip", value_t'(last_fip), value_t'(target));
        check_value("fetch_window[95:0]", value_t'(last_window[95:0]),
                    value_t'(target[0] ? `FETCH_SIG_ODD : `FETCH_SIG_EVEN));
        check_value("fetch_window[127:101]", value_t'(last_window[127:101]),
                    value_t'(target[27:1]));
        await_progress(1'b0, 3, "windows after the redirect");
    endtask

    task automatic predicted_redirect();
        int   start;
        fip_t anchor;
        await_progress(1'b1, 1, "a predicted redirect");
        start  = deliv_count;
        anchor = resteer_base;              // Window that completed the count.
        await_progress(1'b0, 1, "the window at the predicted target");
        check_value("fetch_fip", value_t'(last_fip),
                    value_t'(anchor + fip_t'(`FETCH_RESTEER_STRIDE)));
        await_progress(1'b1, 1, "the next predicted redirect");
        check_value("windows per resteer", value_t'(deliv_count - start), value_t'(PERIOD));
    endtask

    task automatic random_stall();
        int start;
        start = deliv_count;
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            lfsr_state = lfsr_next(lfsr_state);
            stall      = lfsr_state[0];
        end
        @(negedge clk);
        stall = 1'b0;
        if (deliv_count == start) begin
            report_failure("no window delivered under random stall");
        end
        await_progress(1'b0, 4, "windows after the stall ends");
    endtask

    initial begin
        init_valid = 1'b0;
        init_fip   = '0;
        stall      = 1'b0;
        @(negedge rst);
        after_reset_stream();
        miss_refill_gap();
        external_redirect(28'h0123457);
        external_redirect(28'h0400020);
        predicted_redirect();
        random_stall();
        report_and_finish();
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/icache_pkg.sv
rtl/icache_if.sv
rtl/icache_bank.sv
rtl/icache.sv
rtl/fetch_pointer.sv
rtl/resteer_predictor.sv
rtl/fetch_top.sv
sim/clk_gen.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module fetch_tb -f src.f \
    && ./obj_dir/Vfetch_tb | tee sim.log \
    || { echo "Build or simulation run failed."; exit 1; }
grep -qF -- '** FAIL **' sim.log && { echo "Simulation failed."; exit 1; }
grep -qF -- '** PASS **' sim.log || { echo "Simulation gave no result."; exit 1; }
echo "Simulation passed."
